/* Makefile */
# Verilator lint and simulation of the shared wishbone bus

VERILATOR ?= verilator
TOP       ?= bus_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= test failed
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
source/wb_bus_pkg.sv
source/rr_arbiter.sv
source/addr_decoder.sv
source/shared_bus.sv
source/wb_ram_slave.sv
source/bus_top.sv
tests/bus_checker.sv
tests/bus_tb.sv

/* source/addr_decoder.sv */
//=====================================================================
// slave address decoder
// picks the slave window from the bits above the word offset and
// flags addresses that fall outside the map
//=====================================================================

`timescale 1ns/1ps

module addr_decoder #(
    parameter int NUM_SLAVES = 2,
    parameter int WORDS_LOG2 = 6
) (
    input  logic [wb_bus_pkg::ADDR_W-1:0] adr_i,
    output logic [NUM_SLAVES-1:0]         slave_sel_o,
    output logic                          no_hit_o
);

    import wb_bus_pkg::*;

    localparam int IDX_LSB = 2 + WORDS_LOG2;  // just above the word offset
    localparam int IDX_W   = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;
    localparam int TOP_LSB = IDX_LSB + IDX_W;

    logic [IDX_W-1:0] idx;
    logic             upper_zero;
    logic             hit;

    assign idx        = adr_i[IDX_LSB +: IDX_W];
    assign upper_zero = (adr_i[ADDR_W-1:TOP_LSB] == '0);
    assign hit        = upper_zero && (32'(idx) < NUM_SLAVES);  // unused index codes miss

    always_comb begin
        slave_sel_o = '0;
        if (hit) begin
            slave_sel_o[idx] = 1'b1;
        end
    end

    assign no_hit_o = !hit;

endmodule

/* source/bus_top.sv */
//=====================================================================
// shared bus top level
// external masters share one wishbone bus through the round-robin
// arbiter; one memory slave sits behind each decoded window
//=====================================================================

`timescale 1ns/1ps

module bus_top #(
    parameter int NUM_MASTERS = 2,
    parameter int NUM_SLAVES  = 2,
    parameter int WORDS_LOG2  = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  wb_bus_pkg::wb_req_t m_req_i [NUM_MASTERS],
    output wb_bus_pkg::wb_rsp_t m_rsp_o [NUM_MASTERS]
);

    import wb_bus_pkg::*;

    logic [NUM_MASTERS-1:0] cyc_vec;  // arbiter requests
    logic [NUM_MASTERS-1:0] grant;
    wb_req_t                s_req [NUM_SLAVES];
    wb_rsp_t                s_rsp [NUM_SLAVES];

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_cyc
        assign cyc_vec[m] = m_req_i[m].cyc;
    end

    rr_arbiter #(
        .NUM_MASTERS (NUM_MASTERS)
    ) u_arbiter (
        .clk     (clk),
        .reset   (reset),
        .req_i   (cyc_vec),
        .grant_o (grant)
    );

    shared_bus #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES),
        .WORDS_LOG2  (WORDS_LOG2)
    ) u_bus (
        .m_req_i (m_req_i),
        .m_rsp_o (m_rsp_o),
        .grant_i (grant),
        .s_req_o (s_req),
        .s_rsp_i (s_rsp)
    );

    // one memory per slave window
    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        wb_ram_slave #(
            .WORDS_LOG2 (WORDS_LOG2)
        ) u_ram (
            .clk   (clk),
            .reset (reset),
            .req_i (s_req[s]),
            .rsp_o (s_rsp[s])
        );
    end

endmodule

/* source/rr_arbiter.sv */
//=====================================================================
// round-robin bus arbiter
// registered one-hot grant, kept while the owner holds cyc; a free
// bus goes to the first requester after the previous owner
//=====================================================================

`timescale 1ns/1ps

module rr_arbiter #(
    parameter int NUM_MASTERS = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [NUM_MASTERS-1:0] req_i,
    output logic [NUM_MASTERS-1:0] grant_o
);

    localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    logic [NUM_MASTERS-1:0] grant_q;
    logic [NUM_MASTERS-1:0] grant_d;
    logic [IDX_W-1:0]       last_q;  // index of the previous owner
    logic [IDX_W-1:0]       last_d;
    logic                   owner_busy;

    assign owner_busy = |(grant_q & req_i);  // owner still has cyc high

    always_comb begin
        int cand;
        grant_d = grant_q;
        last_d  = last_q;
        cand    = 0;
        if (!owner_busy) begin
            grant_d = '0;
            // walk from the farthest offset down, so the nearest requester wins
            for (int off = NUM_MASTERS; off >= 1; off--) begin
                cand = int'(last_q) + off;
                if (cand >= NUM_MASTERS) begin
                    cand = cand - NUM_MASTERS;
                end
                if (req_i[cand]) begin
                    grant_d       = '0;
                    grant_d[cand] = 1'b1;
                    last_d        = IDX_W'(cand);
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_q <= '0;
            last_q  <= IDX_W'(NUM_MASTERS - 1);  // master 0 goes first
        end else begin
            grant_q <= grant_d;
            last_q  <= last_d;
        end
    end

    assign grant_o = grant_q;

    // never two owners on the bus
    a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant_o))
        else $error("arbiter grant is not one-hot");

    // a fresh grant always lands on a master that was asking for it
    a_grant_to_req: assert property (@(posedge clk) disable iff (reset)
        ($changed(grant_o) && grant_o != '0) |-> |(grant_o & $past(req_i)))
        else $error("arbiter granted a master without a request");

endmodule

/* source/shared_bus.sv */
//=====================================================================
// shared wishbone interconnect
// steers the granted master onto the slave side, strobes the decoded
// slave and returns its data and ack to the owner; misses get err
//=====================================================================

`timescale 1ns/1ps

module shared_bus #(
    parameter int NUM_MASTERS = 2,
    parameter int NUM_SLAVES  = 2,
    parameter int WORDS_LOG2  = 6
) (
    input  wb_bus_pkg::wb_req_t    m_req_i [NUM_MASTERS],
    output wb_bus_pkg::wb_rsp_t    m_rsp_o [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] grant_i,
    output wb_bus_pkg::wb_req_t    s_req_o [NUM_SLAVES],
    input  wb_bus_pkg::wb_rsp_t    s_rsp_i [NUM_SLAVES]
);

    import wb_bus_pkg::*;

    localparam int M_IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;
    localparam int S_IDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

    logic [M_IDX_W-1:0]    gnt_idx;
    logic [S_IDX_W-1:0]    sel_idx;
    wb_req_t               gnt_req;     // request of the current owner
    logic [NUM_SLAVES-1:0] slave_sel;
    logic [NUM_SLAVES-1:0] s_stb;
    logic                  no_hit;
    logic                  gnt_strobe;
    logic                  any_ack;
    logic                  bus_err;
    logic [DATA_W-1:0]     rd_dat;

    // one-hot grant to index
    always_comb begin
        gnt_idx = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (grant_i[m]) begin
                gnt_idx = gnt_idx | M_IDX_W'(m);
            end
        end
    end

    assign gnt_req    = (|grant_i) ? m_req_i[gnt_idx] : '0;  // idle bus drives zeros
    assign gnt_strobe = gnt_req.cyc & gnt_req.stb;

    addr_decoder #(
        .NUM_SLAVES (NUM_SLAVES),
        .WORDS_LOG2 (WORDS_LOG2)
    ) u_decoder (
        .adr_i       (gnt_req.adr),
        .slave_sel_o (slave_sel),
        .no_hit_o    (no_hit)
    );

    assign s_stb = slave_sel & {NUM_SLAVES{gnt_strobe}};

    // same request to every slave, stb only in the selected copy
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            s_req_o[s]     = gnt_req;
            s_req_o[s].stb = s_stb[s];
        end
    end

    // return path
    always_comb begin
        sel_idx = '0;
        any_ack = 1'b0;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (slave_sel[s]) begin
                sel_idx = sel_idx | S_IDX_W'(s);
            end
            any_ack = any_ack | s_rsp_i[s].ack;
        end
    end

    assign rd_dat  = s_rsp_i[sel_idx].dat;
    assign bus_err = gnt_strobe & no_hit;  // nobody maps this address

    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_rsp_o[m].dat = grant_i[m] ? rd_dat : '0;
            m_rsp_o[m].ack = grant_i[m] & any_ack;
            m_rsp_o[m].err = grant_i[m] & bus_err;
        end
    end

    // the decoder select must keep the slave strobes exclusive
    always_comb begin
        a_stb_onehot: assert ($onehot0(s_stb))
            else $error("more than one slave strobe active");
    end

endmodule

/* source/wb_bus_pkg.sv */
//=====================================================================
// wishbone bus definitions
// widths and the request and response structs that every master,
// slave and the interconnect pass around
//=====================================================================

package wb_bus_pkg;

    localparam int ADDR_W = 32;  // byte address
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;  // one select per byte lane

    // master request, 71 bits
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
        logic              we;
        logic              cyc;
        logic              stb;
    } wb_req_t;

    // slave or bus response, 34 bits
    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
        logic              err;
    } wb_rsp_t;

endpackage

/* source/wb_ram_slave.sv */
//=====================================================================
// wishbone classic memory slave
// word-addressed RAM with byte-lane writes and a one-cycle registered
// ack, followed by one idle cycle before the next ack
//=====================================================================

`timescale 1ns/1ps

module wb_ram_slave #(
    parameter int WORDS_LOG2 = 6
) (
    input  logic                clk,
    input  logic                reset,
    input  wb_bus_pkg::wb_req_t req_i,
    output wb_bus_pkg::wb_rsp_t rsp_o
);

    import wb_bus_pkg::*;

    localparam int WORDS = 1 << WORDS_LOG2;

    logic [DATA_W-1:0]     mem [WORDS];
    logic [DATA_W-1:0]     rd_q;
    logic                  ack_q;
    logic [WORDS_LOG2-1:0] word_adr;
    logic                  access;

    assign word_adr = req_i.adr[2 +: WORDS_LOG2];       // drop the byte offset
    assign access   = req_i.cyc & req_i.stb & !ack_q;  // no new access in the ack cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (req_i.sel[b]) begin
                        mem[word_adr][8*b +: 8] <= req_i.dat[8*b +: 8];
                    end
                end
            end else begin
                rd_q <= mem[word_adr];
            end
        end
    end

    assign rsp_o.dat = rd_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;  // every word in the window exists

    // an ack answers a strobe seen one edge earlier
    a_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
        rsp_o.ack |-> $past(req_i.cyc && req_i.stb))
        else $error("memory slave ack without a preceding strobe");

endmodule

/* tests/bus_checker.sv */
//=====================================================================
// bus response checker
// keeps the expected response of every issued transfer per master,
// compares it with what the bus returns and watches block ownership
//=====================================================================

`timescale 1ns/1ps

module bus_checker #(
    parameter int NUM_MASTERS = 2,
    parameter int STUCK_LIMIT = 64
) (
    input  logic                clk,
    input  logic                reset,
    input  wb_bus_pkg::wb_req_t m_req_i [NUM_MASTERS],
    input  wb_bus_pkg::wb_rsp_t m_rsp_i [NUM_MASTERS],
    output int                  value_errs_o,
    output int                  other_errs_o,
    output int                  rsp_cnt_o
);

    import wb_bus_pkg::*;

    string             name_q [NUM_MASTERS][$];
    logic [DATA_W-1:0] dat_q  [NUM_MASTERS][$];
    bit                err_q  [NUM_MASTERS][$];
    bit                rd_q   [NUM_MASTERS][$];
    int                wait_cnt  [NUM_MASTERS];
    int                passed_by [NUM_MASTERS];  // blocks of others ended while waiting
    logic              cyc_prev  [NUM_MASTERS];
    int                blk_owner  = -1;          // master whose open block got the last response
    int                value_errs = 0;
    int                other_errs = 0;
    int                rsp_cnt    = 0;

    assign value_errs_o = value_errs;
    assign other_errs_o = other_errs;
    assign rsp_cnt_o    = rsp_cnt;

    initial begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            wait_cnt[m]  = 0;
            passed_by[m] = 0;
            cyc_prev[m]  = 1'b0;
        end
    end

    // the master driver announces every transfer it starts
    task automatic expect_rsp(input int m, input string name, input logic [DATA_W-1:0] dat,
                              input bit is_err, input bit is_rd);
        name_q[m].push_back(name);
        dat_q[m].push_back(dat);
        err_q[m].push_back(is_err);
        rd_q[m].push_back(is_rd);
    endtask

    task automatic check_rsp(input int m);
        string             nm;
        logic [DATA_W-1:0] exp_dat;
        bit                exp_err;
        bit                is_rd;
        if (name_q[m].size() == 0) begin
            $display("master %0d got a response with no transfer outstanding at %0t", m, $time);
            other_errs++;
        end else begin
            nm      = name_q[m].pop_front();
            exp_dat = dat_q[m].pop_front();
            exp_err = err_q[m].pop_front();
            is_rd   = rd_q[m].pop_front();
            rsp_cnt++;
            if (m_rsp_i[m].err !== exp_err) begin
                $display("** Error %s: expected %s, actual %s", nm,
                         exp_err ? "err" : "ack", m_rsp_i[m].err ? "err" : "ack");
                value_errs++;
            end else if (is_rd && !exp_err && m_rsp_i[m].dat !== exp_dat) begin
                $display("** Error %s: expected %h, actual %h", nm, exp_dat, m_rsp_i[m].dat);
                value_errs++;
            end
        end
    endtask

    // outputs are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        int n_rsp;
        n_rsp = 0;
        if (!reset) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if ($isunknown({m_rsp_i[m].ack, m_rsp_i[m].err})) begin
                    $display("master %0d sees an unknown ack or err at %0t", m, $time);
                    other_errs++;
                end else if (m_rsp_i[m].ack && m_rsp_i[m].err) begin
                    $display("master %0d sees ack and err together at %0t", m, $time);
                    other_errs++;
                end else if (m_rsp_i[m].ack || m_rsp_i[m].err) begin
                    n_rsp++;
                    if (blk_owner >= 0 && blk_owner != m && m_req_i[blk_owner].cyc) begin
                        $display("master %0d answered inside the block of master %0d",
                                 m, blk_owner);
                        other_errs++;
                    end
                    blk_owner    = m;
                    wait_cnt[m]  = 0;
                    passed_by[m] = 0;
                    check_rsp(m);
                end else if (name_q[m].size() != 0) begin
                    wait_cnt[m]++;
                    if (wait_cnt[m] == STUCK_LIMIT) begin
                        $display("transfer of master %0d is stuck without ack or err", m);
                        other_errs++;
                    end
                end
                if (cyc_prev[m] && !m_req_i[m].cyc) begin  // block of master m ended
                    if (blk_owner == m) begin
                        blk_owner = -1;  // its next block starts fresh
                    end
                    for (int w = 0; w < NUM_MASTERS; w++) begin
                        if (w != m && name_q[w].size() != 0) begin
                            passed_by[w]++;
                            if (passed_by[w] == 2) begin
                                $display("master %0d kept waiting while master %0d got a second block",
                                         w, m);
                                other_errs++;
                            end
                        end
                    end
                end
                cyc_prev[m] = m_req_i[m].cyc;
            end
            if (n_rsp > 1) begin
                $display("responses reached more than one master at %0t", $time);
                other_errs++;
            end
        end
    end

endmodule

/* tests/bus_input.txt */
# name master we adr dat sel exp_rd rsp end (adr, dat, sel, exp_rd in hex)
# rsp is ack or err, end is 1 on the last line of a block
m0_wr_s0     0 1 00000000 11223344 f 00000000 ack 0
m1_wr_a      1 1 00000080 01020304 f 00000000 ack 0
m0_wr_s0b    0 1 00000008 a5a5a5a5 f 00000000 ack 0
m1_wr_b      1 1 00000184 89abcdef f 00000000 ack 0
m0_rd_s0     0 0 00000000 00000000 f 11223344 ack 1
m1_rd_a      1 0 00000080 00000000 f 01020304 ack 0
m0_part_wr   0 1 00000000 ffeeddcc 5 00000000 ack 0
m1_rd_b      1 0 00000184 00000000 f 89abcdef ack 1
m0_part_rd   0 0 00000000 00000000 f 11ee33cc ack 1
m1_part_wr   1 1 00000080 ffffffff 8 00000000 ack 0
m0_wr_s1     0 1 00000104 cafef00d f 00000000 ack 1
m1_part_rd   1 0 00000080 00000000 f ff020304 ack 1
m0_part_s1   0 1 00000104 12345678 a 00000000 ack 0
m1_wr_c      1 1 00000180 5a5a5a5a f 00000000 ack 1
m0_rd_s1     0 0 00000104 00000000 f 12fe560d ack 1
m1_err_wr    1 1 00000380 00000000 f 00000000 err 0
m0_err_hi    0 1 00000208 deadbeef f 00000000 err 0
m1_err_rd    1 0 00000200 00000000 f 00000000 err 1
m0_err_far   0 0 80000000 00000000 f 00000000 err 0
m1_rd_c      1 0 00000180 00000000 f 5a5a5a5a ack 1
m0_chk_alias 0 0 00000008 00000000 f a5a5a5a5 ack 1
m1_blk_w0    1 1 000000f0 0000f0f0 f 00000000 ack 0
m0_blk_w0    0 1 00000110 00000010 f 00000000 ack 0
m1_blk_r0    1 0 000000f0 00000000 f 0000f0f0 ack 1
m0_blk_w1    0 1 00000114 00000011 f 00000000 ack 0
m0_blk_r0    0 0 00000110 00000000 f 00000010 ack 0
m0_blk_r1    0 0 00000114 00000000 f 00000011 ack 1

/* tests/bus_tb.sv */
//=====================================================================
// shared bus testbench
// two file-driven wishbone masters compete for the bus; a separate
// checker compares every response with the expected one
//=====================================================================

`timescale 1ns/1ps

module bus_tb;

    import wb_bus_pkg::*;

    localparam int NUM_MASTERS     = 2;
    localparam int NUM_SLAVES      = 2;
    localparam int WORDS_LOG2      = 6;
    localparam int PERIOD          = 4;  // ns
    localparam int RESET_CYCLES    = 3;
    localparam int CYCLES_PER_LINE = 10;
    localparam int TIMEOUT_MARGIN  = 100;
    localparam int MAX_LINES       = 64;

    logic    clk;
    logic    reset;
    wb_req_t m_req [NUM_MASTERS];
    wb_rsp_t m_rsp [NUM_MASTERS];

    // transaction table, one entry per file line
    string             name_tab [MAX_LINES];
    int                mst_tab  [MAX_LINES];
    logic              we_tab   [MAX_LINES];
    logic [ADDR_W-1:0] adr_tab  [MAX_LINES];
    logic [DATA_W-1:0] dat_tab  [MAX_LINES];
    logic [SEL_W-1:0]  sel_tab  [MAX_LINES];
    logic [DATA_W-1:0] exp_tab  [MAX_LINES];
    bit                err_tab  [MAX_LINES];
    bit                end_tab  [MAX_LINES];  // last line of a block
    int                n_lines   = 0;
    bit                loaded    = 1'b0;
    bit                run_go    = 1'b0;
    bit                drv_done  [NUM_MASTERS];
    int                tb_errs   = 0;
    int                cycle_cnt = 0;
    int                value_errs;
    int                other_errs;
    int                rsp_cnt;

    always #(PERIOD / 2) clk = ~clk;

    bus_top #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES),
        .WORDS_LOG2  (WORDS_LOG2)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .m_req_i (m_req),
        .m_rsp_o (m_rsp)
    );

    bus_checker #(
        .NUM_MASTERS (NUM_MASTERS)
    ) chk0 (
        .clk          (clk),
        .reset        (reset),
        .m_req_i      (m_req),
        .m_rsp_i      (m_rsp),
        .value_errs_o (value_errs),
        .other_errs_o (other_errs),
        .rsp_cnt_o    (rsp_cnt)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic load_table();
        int    fd;
        int    n;
        int    mst;
        int    we;
        int    last;
        string line;
        string nm;
        string rsp;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
        logic [DATA_W-1:0] exp_rd;
        fd = $fopen("tests/bus_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/bus_input.txt");
            tb_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin  // skip blanks and comments
                n = $sscanf(line, "%s %d %d %h %h %h %h %s %d",
                            nm, mst, we, adr, dat, sel, exp_rd, rsp, last);
                if (n != 9 || n_lines >= MAX_LINES) begin
                    $display("unreadable line in the input file: %s", line);
                    tb_errs++;
                end else begin
                    name_tab[n_lines] = nm;
                    mst_tab[n_lines]  = mst;
                    we_tab[n_lines]   = (we != 0);
                    adr_tab[n_lines]  = adr;
                    dat_tab[n_lines]  = dat;
                    sel_tab[n_lines]  = sel;
                    exp_tab[n_lines]  = exp_rd;
                    err_tab[n_lines]  = (rsp == "err");
                    end_tab[n_lines]  = (last != 0);
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // one driver per master, working through its own lines in file order
    for (genvar g = 0; g < NUM_MASTERS; g++) begin : g_master
        wb_req_t req;
        assign m_req[g] = req;

        initial begin
            logic [31:0] rng;
            bit          in_blk;
            int          gap;
            req         <= '0;
            drv_done[g]  = 1'b0;
            in_blk       = 1'b0;
            rng          = 32'd93;
            for (int i = 0; i < g; i++) begin
                rng = next_rand(rng);  // separate stream per master
            end
            wait (run_go);
            for (int i = 0; i < n_lines; i++) begin
                if (mst_tab[i] == g) begin
                    if (!in_blk) begin
                        rng = next_rand(rng);
                        gap = int'(rng[1:0]);  // 0 to 3 idle cycles before a block
                        repeat (gap) @(negedge clk);
                    end
                    @(negedge clk);
                    req.adr <= adr_tab[i];
                    req.dat <= dat_tab[i];
                    req.sel <= sel_tab[i];
                    req.we  <= we_tab[i];
                    req.cyc <= 1'b1;
                    req.stb <= 1'b1;
                    chk0.expect_rsp(g, name_tab[i], exp_tab[i], err_tab[i], !we_tab[i]);
                    do @(negedge clk); while (!(m_rsp[g].ack || m_rsp[g].err));
                    req.stb <= 1'b0;
                    if (end_tab[i]) begin
                        req.cyc <= 1'b0;
                    end
                    in_blk = !end_tab[i];
                end
            end
            drv_done[g] = 1'b1;
        end
    end

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        load_table();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset  = 1'b0;
        run_go = 1'b1;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            wait (drv_done[m] == 1'b1);
        end
        repeat (4) @(negedge clk);
        if (rsp_cnt != n_lines) begin
            $display("only %0d of %0d transfers got the expected response", rsp_cnt, n_lines);
            tb_errs++;
        end
        $display("errors: %0d value, %0d protocol, %0d testbench, %0d transfers checked",
                 value_errs, other_errs, tb_errs, rsp_cnt);
        if (value_errs + other_errs + tb_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // run limit grows with the number of transfers in the file
    initial begin
        wait (loaded);
        while (cycle_cnt < n_lines * CYCLES_PER_LINE + TIMEOUT_MARGIN) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: transfers still unfinished after %0d cycles", cycle_cnt);
        $display("test failed");
        $finish;
    end

endmodule
